/* soc_pkg.sv */
/*
 * soc_pkg
 * bus opcodes and the data, address and counter widths
 * shared by the peripheral subsystem
 */
package soc_pkg;

	// word-access bus, 32-bit architecture
	localparam int DATA_W = 32;

	// word address, byte offset bits dropped
	localparam int ADDR_W = 30;

	// bus opcode, held for a single cycle per access
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10
	} pi1_op_e;

	// reset hold-off, short so that simulation stays quick
	localparam int RST_CNTR_W = 5;

	// activity dimming hold-off
	localparam int ACT_CNTR_W = 7;

endpackage

/* devmap_pkg.sv */
/*
 * devmap_pkg
 * slave indices, address map, device table contents
 * and software reset codes
 */
package devmap_pkg;

	typedef enum logic [1:0] {
		S_DEVTBL  = 2'd0,
		S_GPIO    = 2'd1,
		S_INVALID = 2'd2
	} slave_e;

	localparam int SLAVE_COUNT = 3;

	// offset into a slave, wide enough for the largest mapped slave
	localparam int OFFS_W = 4;

	// word bases and sizes
	localparam int DEVTBL_BASE   = 0;
	localparam int DEVTBL_MAPSZ  = 16;
	localparam int GPIO_BASE     = 16;
	localparam int GPIO_MAPSZ    = 4;
	localparam int INVALID_MAPSZ = 1024;

	// device table contents, indexed by slave_e
	localparam int unsigned DEV_ID [SLAVE_COUNT] = '{7, 6, 0};
	localparam int unsigned DEV_MAPSZ [SLAVE_COUNT] = '{DEVTBL_MAPSZ, GPIO_MAPSZ, INVALID_MAPSZ};
	localparam logic [SLAVE_COUNT-1:0] DEV_USEINTR = 3'b010;

	// device table register offsets
	localparam int DEVTBL_MAPSZ_OFFS   = 4;
	localparam int DEVTBL_USEINTR_OFFS = 8;
	localparam int DEVTBL_SWRST_OFFS   = 15;

	// bit 0 is the power-off request, bit 1 the restart request
	typedef enum logic [1:0] {
		RST_NONE   = 2'b00,
		RST_PWROFF = 2'b01,
		RST_WARM   = 2'b10,
		RST_COLD   = 2'b11
	} swrst_e;

	// gpio pins and register offsets
	localparam int GPIO_COUNT    = 8;
	localparam int GPIO_IN_OFFS  = 0;
	localparam int GPIO_OUT_OFFS = 1;

endpackage

/* rst_sequencer.sv */
/*
 * rst_sequencer
 * holds the subsystem in reset with a down-counter, restarts it on
 * a software warm or cold reset and latches a software power-off
 */
module rst_sequencer
	import soc_pkg::*;
	import devmap_pkg::*;
(
	input  logic   clk_2x_w,
	input  logic   rst_p,
	input  swrst_e swrst_i,
	output logic   sys_rst_o
);

	logic [RST_CNTR_W-1:0] rst_cntr_q;
	logic                  pwroff_q;
	logic                  restart_w;

	// cold acts as warm here, both simply restart the count
	assign restart_w = (swrst_i == RST_WARM) || (swrst_i == RST_COLD);

	always_ff @(posedge clk_2x_w) begin
		if (rst_p || restart_w) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// power-off holds until the next external reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (swrst_i == RST_PWROFF) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = pwroff_q || (rst_cntr_q != '0);

endmodule

/* pi1_decoder.sv */
/*
 * pi1_decoder
 * routes each bus access to one slave by address and returns its
 * response one cycle later; unmapped addresses read zero
 */
module pi1_decoder
	import soc_pkg::*;
	import devmap_pkg::*;
(
	input  logic              clk_2x_w,
	input  logic              sys_rst_i,
	input  pi1_op_e           m_op_i,
	input  logic [ADDR_W-1:0] m_addr_i,
	input  logic [DATA_W-1:0] m_data_i,
	output logic [DATA_W-1:0] m_data_o,
	output logic              m_rdy_o,
	output pi1_op_e           dev_op_o,
	output pi1_op_e           gpio_op_o,
	output logic [OFFS_W-1:0] s_addr_o,
	output logic [DATA_W-1:0] s_data_o,
	input  logic [DATA_W-1:0] dev_data_i,
	input  logic [DATA_W-1:0] gpio_data_i
);

	slave_e            sel_w;
	slave_e            sel_q;
	logic [ADDR_W-1:0] base_w;
	logic              rdy_q;

	// address compare against each slave window
	always_comb begin
		sel_w  = S_INVALID;
		base_w = '0;
		if (m_addr_i >= ADDR_W'(DEVTBL_BASE) &&
			m_addr_i < ADDR_W'(DEVTBL_BASE + DEVTBL_MAPSZ)) begin
			sel_w  = S_DEVTBL;
			base_w = ADDR_W'(DEVTBL_BASE);
		end else if (m_addr_i >= ADDR_W'(GPIO_BASE) &&
			m_addr_i < ADDR_W'(GPIO_BASE + GPIO_MAPSZ)) begin
			sel_w  = S_GPIO;
			base_w = ADDR_W'(GPIO_BASE);
		end
	end

	// only the selected slave sees the strobe
	assign dev_op_o  = (sel_w == S_DEVTBL) ? m_op_i : PI1_NOP;
	assign gpio_op_o = (sel_w == S_GPIO) ? m_op_i : PI1_NOP;
	assign s_addr_o  = OFFS_W'(m_addr_i - base_w);
	assign s_data_o  = m_data_i;

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
			sel_q <= S_INVALID;
		end else begin
			rdy_q <= (m_op_i != PI1_NOP);
			sel_q <= sel_w;
		end
	end

	// invalid device answers zero
	always_comb begin
		case (sel_q)
			S_DEVTBL: m_data_o = dev_data_i;
			S_GPIO:   m_data_o = gpio_data_i;
			default:  m_data_o = '0;
		endcase
	end

	assign m_rdy_o = rdy_q;

endmodule

/* devtbl.sv */
/*
 * devtbl
 * read-only device table of ids, map sizes and interrupt use,
 * plus the software reset control register
 */
module devtbl
	import soc_pkg::*;
	import devmap_pkg::*;
(
	input  logic              clk_2x_w,
	input  logic              sys_rst_i,
	input  pi1_op_e           op_i,
	input  logic [OFFS_W-1:0] addr_i,
	input  logic [DATA_W-1:0] data_i,
	output logic [DATA_W-1:0] data_o,
	output swrst_e            swrst_o
);

	logic [DATA_W-1:0] rd_w;
	logic [DATA_W-1:0] data_q;
	swrst_e            swrst_q;

	// table lookup, low two offset bits pick the slave
	always_comb begin
		rd_w = '0;
		if (addr_i < OFFS_W'(SLAVE_COUNT)) begin
			rd_w = DATA_W'(DEV_ID[addr_i[1:0]]);
		end else if (addr_i >= OFFS_W'(DEVTBL_MAPSZ_OFFS) &&
			addr_i < OFFS_W'(DEVTBL_MAPSZ_OFFS + SLAVE_COUNT)) begin
			rd_w = DATA_W'(DEV_MAPSZ[addr_i[1:0]]);
		end else if (addr_i == OFFS_W'(DEVTBL_USEINTR_OFFS)) begin
			rd_w = DATA_W'(DEV_USEINTR);
		end else if (addr_i == OFFS_W'(DEVTBL_SWRST_OFFS)) begin
			rd_w = DATA_W'(swrst_q);
		end
	end

	// read data one cycle after the strobe, zero otherwise
	always_ff @(posedge clk_2x_w) begin
		if (op_i == PI1_RD) begin
			data_q <= rd_w;
		end else begin
			data_q <= '0;
		end
	end

	// software reset request, cleared once the reset takes hold
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			swrst_q <= RST_NONE;
		end else if (op_i == PI1_WR && addr_i == OFFS_W'(DEVTBL_SWRST_OFFS)) begin
			swrst_q <= swrst_e'(data_i[1:0]);
		end
	end

	assign data_o  = data_q;
	assign swrst_o = swrst_q;

endmodule

/* gpio_port.sv */
/*
 * gpio_port
 * synchronized input pins and an output register on the bus,
 * pin 0 is input only
 */
module gpio_port
	import soc_pkg::*;
	import devmap_pkg::*;
(
	input  logic                  clk_2x_w,
	input  logic                  sys_rst_i,
	input  pi1_op_e               op_i,
	input  logic [OFFS_W-1:0]     addr_i,
	input  logic [DATA_W-1:0]     data_i,
	output logic [DATA_W-1:0]     data_o,
	input  logic [GPIO_COUNT-1:0] gp_i,
	output logic [GPIO_COUNT-1:1] gp_o_o
);

	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;
	logic [GPIO_COUNT-1:1] out_q;
	logic [DATA_W-1:0]     data_q;

	// two-flop synchronizer on the pins
	always_ff @(posedge clk_2x_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			out_q <= '0;
		end else if (op_i == PI1_WR && addr_i == OFFS_W'(GPIO_OUT_OFFS)) begin
			out_q <= data_i[GPIO_COUNT-1:1];
		end
	end

	always_ff @(posedge clk_2x_w) begin
		data_q <= '0;
		if (op_i == PI1_RD && addr_i == OFFS_W'(GPIO_IN_OFFS)) begin
			data_q <= DATA_W'(sync2_q);
		end else if (op_i == PI1_RD && addr_i == OFFS_W'(GPIO_OUT_OFFS)) begin
			data_q <= DATA_W'({out_q, 1'b0});
		end
	end

	assign data_o = data_q;
	assign gp_o_o = out_q;

endmodule

/* activity_led.sv */
/*
 * activity_led
 * one-cycle activity pulse per request, dimmed by a hold-off counter
 */
module activity_led
	import soc_pkg::*;
(
	input  logic clk_2x_w,
	input  logic sys_rst_i,
	input  logic req_i,
	output logic activity_o
);

	logic [ACT_CNTR_W-1:0] cntr_q;
	logic                  act_q;

	// requests arriving during the hold-off are dropped
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			cntr_q <= '0;
			act_q  <= 1'b0;
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
			act_q  <= 1'b0;
		end else begin
			cntr_q <= req_i ? '1 : '0;
			act_q  <= req_i;
		end
	end

	assign activity_o = act_q;

endmodule

/* soc_top.sv */
/*
 * soc_top
 * peripheral bus subsystem: reset sequencer, address decoder,
 * device table, gpio port and activity indicator
 */
module soc_top
	import soc_pkg::*;
	import devmap_pkg::*;
(
	input  logic                  clk_2x_w,
	input  logic                  rst_p,
	input  pi1_op_e               m_op_i,
	input  logic [ADDR_W-1:0]     m_addr_i,
	input  logic [DATA_W-1:0]     m_data_i,
	output logic [DATA_W-1:0]     m_data_o,
	output logic                  m_rdy_o,
	input  logic [GPIO_COUNT-1:0] gp_i,
	output logic [GPIO_COUNT-1:1] gp_o_o,
	output logic                  sys_rst_o,
	output logic                  activity_o
);

	pi1_op_e           dev_op_w;
	pi1_op_e           gpio_op_w;
	logic [OFFS_W-1:0] s_addr_w;
	logic [DATA_W-1:0] s_data_w;
	logic [DATA_W-1:0] dev_data_w;
	logic [DATA_W-1:0] gpio_data_w;
	swrst_e            swrst_w;

	rst_sequencer u_rst_sequencer (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.swrst_i   (swrst_w),
		.sys_rst_o (sys_rst_o)
	);

	pi1_decoder u_pi1_decoder (
		.clk_2x_w    (clk_2x_w),
		.sys_rst_i   (sys_rst_o),
		.m_op_i      (m_op_i),
		.m_addr_i    (m_addr_i),
		.m_data_i    (m_data_i),
		.m_data_o    (m_data_o),
		.m_rdy_o     (m_rdy_o),
		.dev_op_o    (dev_op_w),
		.gpio_op_o   (gpio_op_w),
		.s_addr_o    (s_addr_w),
		.s_data_o    (s_data_w),
		.dev_data_i  (dev_data_w),
		.gpio_data_i (gpio_data_w)
	);

	devtbl u_devtbl (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.op_i      (dev_op_w),
		.addr_i    (s_addr_w),
		.data_i    (s_data_w),
		.data_o    (dev_data_w),
		.swrst_o   (swrst_w)
	);

	gpio_port u_gpio_port (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.op_i      (gpio_op_w),
		.addr_i    (s_addr_w),
		.data_i    (s_data_w),
		.data_o    (gpio_data_w),
		.gp_i      (gp_i),
		.gp_o_o    (gp_o_o)
	);

	// any bus access counts as activity
	activity_led u_activity_led (
		.clk_2x_w   (clk_2x_w),
		.sys_rst_i  (sys_rst_o),
		.req_i      (m_op_i != PI1_NOP),
		.activity_o (activity_o)
	);

endmodule

/* soc_props.sv */
/*
 * soc_props
 * bus response and activity pulse timing assertions on soc_top
 */
module soc_props
	import soc_pkg::*;
(
	input logic    clk_2x_w,
	input logic    rst_p,
	input pi1_op_e m_op_i,
	input logic    m_rdy_o,
	input logic    sys_rst_o,
	input logic    activity_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// count of failed assertions
	int assert_errs = 0;

	// every access outside reset is answered in the next cycle
	rdy_follows_req: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		(m_op_i != PI1_NOP && !sys_rst_o) |=> m_rdy_o)
		else begin
			$error("access outside reset got no ready in the next cycle");
			assert_errs++;
		end

	rdy_needs_req: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		m_rdy_o |-> $past(m_op_i != PI1_NOP))
		else begin
			$error("ready seen without a request in the previous cycle");
			assert_errs++;
		end

	// dimming keeps pulses at least 128 cycles apart
	act_spacing: assert property (@(posedge clk_2x_w) disable iff (sys_rst_o)
		activity_o |=> !activity_o [*127])
		else begin
			$error("activity pulses closer than 128 cycles");
			assert_errs++;
		end

endmodule

bind soc_top soc_props props0 (.*);

/* tb_soc.sv */
/*
 * tb_soc
 * seeded random bus traffic against a model of the device table,
 * gpio port, address map and activity hold-off
 */
module tb_soc
	import soc_pkg::*;
	import devmap_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// tests take roughly a thousand cycles including the reset waits
	localparam int MAX_CYCLES = 4000;

	logic                  clk_2x_w;
	logic                  rst_p;
	pi1_op_e               m_op_i;
	logic [ADDR_W-1:0]     m_addr_i;
	logic [DATA_W-1:0]     m_data_i;
	logic [DATA_W-1:0]     m_data_o;
	logic                  m_rdy_o;
	logic [GPIO_COUNT-1:0] gp_i;
	logic [GPIO_COUNT-1:1] gp_o_o;
	logic                  sys_rst_o;
	logic                  activity_o;

	// model of the gpio registers
	logic [GPIO_COUNT-1:1] gp_out_m;
	logic [GPIO_COUNT-1:0] gp_in_m;
	int                    cycle_cnt = 0;

	soc_top dut0 (.*);

	initial begin
		clk_2x_w = 1'b0;
		forever #50 clk_2x_w = ~clk_2x_w;
	end

	always @(posedge clk_2x_w) begin
		cycle_cnt++;
		if (dut0.props0.assert_errs != 0) begin
			abort_run("a bound assertion on the bus or activity timing failed");
		end else if (cycle_cnt >= MAX_CYCLES) begin
			abort_run("simulation ran past its cycle limit without finishing");
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
		end
	endtask

	// expected read data from the address map and device table rules
	function automatic logic [DATA_W-1:0] expect_read(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] val;
		int                k;
		val = '0;
		k = 0;
		if (addr < DEVTBL_BASE + DEVTBL_MAPSZ) begin
			k = int'(addr) - DEVTBL_BASE;
			if (k < SLAVE_COUNT) begin
				val = DEV_ID[k];
			end else if (k >= 4 && k < 4 + SLAVE_COUNT) begin
				val = DEV_MAPSZ[k - 4];
			end else if (k == 8) begin
				val = DEV_USEINTR;
			end
			// offset 15 reads RST_NONE outside a software reset
		end else if (addr >= GPIO_BASE && addr < GPIO_BASE + GPIO_MAPSZ) begin
			k = int'(addr) - GPIO_BASE;
			if (k == 0) begin
				val = gp_in_m;
			end else if (k == 1) begin
				val = {gp_out_m, 1'b0};
			end
		end
		return val;
	endfunction

	// one strobe with its response checked one cycle later
	task automatic access(input pi1_op_e op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, input string name);
		logic [DATA_W-1:0] exp;
		exp = (op == PI1_RD) ? expect_read(addr) : '0;
		m_op_i   = op;
		m_addr_i = addr;
		m_data_i = wdata;
		@(negedge clk_2x_w);
		m_op_i = PI1_NOP;
		check({name, " ready"}, 1, m_rdy_o);
		check(name, exp, m_data_o);
		if (op == PI1_WR && addr == GPIO_BASE + 1) begin
			gp_out_m = wdata[GPIO_COUNT-1:1];
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk_2x_w);
			check("idle ready", 0, m_rdy_o);
		end
	endtask

	task automatic wait_rst(input logic lvl, input int limit, input string what);
		int n;
		n = 0;
		while (sys_rst_o !== lvl) begin
			if (n == limit) begin
				abort_run({what, " did not happen within the expected cycles"});
			end
			@(negedge clk_2x_w);
			n++;
		end
	endtask

	task automatic apply_reset();
		rst_p = 1'b1;
		repeat (16) @(negedge clk_2x_w);
		rst_p = 1'b0;
		wait_rst(1'b0, 40, "release of system reset");
		gp_out_m = '0;
		check("ready after reset", 0, m_rdy_o);
		check("activity after reset", 0, activity_o);
		check("gpio out after reset", 0, gp_o_o);
	endtask

	initial begin
		int                i;
		int                k;
		int                hold;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		logic              req;
		logic              exp_act;
		rst_p    = 1'b1;
		m_op_i   = PI1_NOP;
		m_addr_i = '0;
		m_data_i = '0;
		gp_i     = '0;
		gp_in_m  = '0;
		gp_out_m = '0;
		void'($urandom(78));
		apply_reset();

		// device table at random offsets and spacing
		for (i = 0; i < 40; i++) begin
			a = ADDR_W'(DEVTBL_BASE + $urandom_range(DEVTBL_MAPSZ - 1));
			access(PI1_RD, a, '0, $sformatf("devtbl read %0d", a));
			idle($urandom_range(2));
		end

		for (i = 0; i < 20; i++) begin
			d = $urandom();
			access(PI1_WR, ADDR_W'(GPIO_BASE + 1), d, "gpio write");
			check("gpio pins", gp_out_m, gp_o_o);
			access(PI1_RD, ADDR_W'(GPIO_BASE + 1), '0, "gpio out readback");
			gp_i    = GPIO_COUNT'($urandom());
			gp_in_m = gp_i;
			hold = 3 + $urandom_range(2);
			idle(hold);
			access(PI1_RD, ADDR_W'(GPIO_BASE), '0, "gpio in read");
		end

		// unmapped addresses with some strobes back to back
		for (i = 0; i < 30; i++) begin
			a = ADDR_W'($urandom());
			if (a < GPIO_BASE + GPIO_MAPSZ) begin
				a = a + ADDR_W'(GPIO_BASE + GPIO_MAPSZ);
			end
			access($urandom_range(1) ? PI1_RD : PI1_WR, a, $urandom(), "invalid access");
			idle($urandom_range(1));
		end

		access(PI1_WR, ADDR_W'(GPIO_BASE + 1), 32'h0000_00fe, "gpio write before reset");
		access(PI1_WR, ADDR_W'(DEVTBL_BASE + 15), DATA_W'(RST_WARM), "warm reset write");
		wait_rst(1'b1, 4, "entry into warm reset");
		wait_rst(1'b0, 40, "release of warm reset");
		gp_out_m = '0;
		access(PI1_RD, ADDR_W'(GPIO_BASE + 1), '0, "gpio out after warm reset");
		access(PI1_RD, ADDR_W'(DEVTBL_BASE + 15), '0, "swrst after warm reset");

		// power-off holds reset and drops every access
		access(PI1_WR, ADDR_W'(DEVTBL_BASE + 15), DATA_W'(RST_PWROFF), "power-off write");
		wait_rst(1'b1, 4, "entry into power-off");
		for (i = 0; i < 200; i++) begin
			m_op_i = $urandom_range(1) ? PI1_RD : PI1_NOP;
			@(negedge clk_2x_w);
			check("power-off hold", 1, sys_rst_o);
			check("ready in power-off", 0, m_rdy_o);
		end
		m_op_i = PI1_NOP;
		apply_reset();

		// hold-off is clear after reset and the first half is continuous traffic
		k = 0;
		for (i = 0; i < 300; i++) begin
			req = (i < 150) || ($urandom_range(3) != 0);
			exp_act = req && (k == 0);
			if (req) begin
				access(PI1_RD, ADDR_W'(GPIO_BASE), '0, "activity traffic");
			end else begin
				idle(1);
			end
			check("activity pulse", exp_act, activity_o);
			if (k != 0) begin
				k--;
			end else if (req) begin
				k = 127;
			end
		end

		idle(2);
		if (dut0.props0.assert_errs != 0) begin
			abort_run("a bound assertion on the bus or activity timing failed");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* build.f */
soc_pkg.sv
devmap_pkg.sv
rst_sequencer.sv
pi1_decoder.sv
devtbl.sv
gpio_port.sv
activity_led.sv
soc_top.sv
soc_props.sv
tb_soc.sv

/* Bender.yml */
package:
  name: soc_periph

sources:
  - soc_pkg.sv
  - devmap_pkg.sv
  - rst_sequencer.sv
  - pi1_decoder.sv
  - devtbl.sv
  - gpio_port.sv
  - activity_led.sv
  - soc_top.sv
  - target: test
    files:
      - soc_props.sv
      - tb_soc.sv
